// File: boot_image.hex
08000020
00000000
4d495053
2d536f43
20626f6f
7420524f
4d0d0a00
4c6f6164
696e6720
696d6167
65206672
6f6d2055
4152542e
2e2e0d0a
00000000
43686563
6b73756d
20657272
6f720d0a
00000000
4a756d70
696e6720
746f2061
70700d0a
00000000
4d656d20
74657374
20666169
6c65640d
0a000000
3e200000
00000000
3c1d1000
37bd0ffc
3c040000
24840008
0c00002c
00000000
3c081000
8d090000
1120fffe
00000000
01200008
00000000
80820000
03e00008
00000000
0800002f

// File: boot_rom.sv
`timescale 1ns/1ps
`default_nettype none

module boot_rom (
        input  logic clka,
        input  logic ena,
        input  logic enb,
        input  logic [mem_pkg::rom_aw-1:0] addra,
        input  logic [mem_pkg::rom_aw-1:0] addrb,
        output logic [mem_pkg::data_w-1:0] doa,
        output logic [mem_pkg::data_w-1:0] dob
);

        logic [mem_pkg::data_w-1:0] rom [mem_pkg::rom_words];

        // image holds the first 48 words, everything past it reads as zero
        initial begin
                for (int i = 0; i < mem_pkg::rom_words; i++) begin
                        rom[i] = '0;
                end
                $readmemh("boot_image.hex", rom, 0, 47);
        end

        // instruction fetch side
        always_ff @(posedge clka) begin
                if (ena) begin
                        doa <= rom[addra];
                end
        end

        always_ff @(posedge clka) begin
                if (enb) begin
                        dob <= rom[addrb];      // data side, string constants
                end
        end

endmodule

`default_nettype wire

// File: compile.f
mem_pkg.sv
boot_rom.sv
data_ram.sv
mem_port.sv
mem_top.sv
mem_chk.sv
mem_tb.sv

// File: data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram (
        input  logic clka,
        input  logic en,
        input  logic we,
        input  logic [mem_pkg::ram_aw-1:0] addr,
        input  logic [mem_pkg::data_w-1:0] wdata,
        output logic [mem_pkg::data_w-1:0] rdata
);

        logic [mem_pkg::data_w-1:0] mem [mem_pkg::ram_words];

        // read data only updates on a read, a write leaves it alone
        always_ff @(posedge clka) begin
                if (en) begin
                        if (we) begin
                                mem[addr] <= wdata;
                        end else begin
                                rdata <= mem[addr];
                        end
                end
        end

endmodule

`default_nettype wire

// File: mem_chk.sv
`timescale 1ns/1ps
`default_nettype none

module mem_chk #(
        parameter bit has_ram = 1'b0
) (
        input logic clka,
        input logic rst_n,
        input logic req_valid,
        input logic req_credit,
        input logic rsp_valid,
        input logic rsp_credit,
        input logic ram_en,
        input logic ram_we
);

        localparam logic [2:0] limit = 3'(mem_pkg::port_credits);

        logic [2:0] held;       // response credits held by the port
        logic [2:0] inflight;   // requests whose credit has not come back yet

        always_ff @(posedge clka) begin
                if (!rst_n) begin
                        held <= limit;
                        inflight <= '0;
                end else begin
                        held <= held + 3'(rsp_credit) - 3'(rsp_valid);
                        inflight <= inflight + 3'(req_valid) - 3'(req_credit);
                end
        end

        rsp_has_credit: assert property (@(posedge clka) disable iff (!rst_n)
                rsp_valid |-> held != '0)
                else $error("response sent with no response credit held");

        req_within_credit: assert property (@(posedge clka) disable iff (!rst_n)
                req_valid |-> inflight < limit)
                else $error("request issued beyond the credit limit");

        inflight_bound: assert property (@(posedge clka) disable iff (!rst_n)
                inflight <= limit)
                else $error("more requests in flight than credits");

        // first reset edge clears it, so look one cycle on
        no_credit_in_reset: assert property (@(posedge clka) !rst_n |=> !req_credit)
                else $error("req_credit high during reset");

        fetch_port_no_ram: assert property (@(posedge clka) !has_ram |-> !(ram_en || ram_we))
                else $error("RAM access from a port without RAM");

endmodule

bind mem_port mem_chk #(.has_ram(has_ram)) chk (
        .clka       (clka),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_credit (req_credit),
        .rsp_valid  (rsp_valid),
        .rsp_credit (rsp_credit),
        .ram_en     (ram_en),
        .ram_we     (ram_we)
);

`default_nettype wire

// File: mem_patterns.txt
# port we addr wdata exp_rdata exp_err, all hex, port 0 is fetch port A, port 1 is data port B
# each port issues its own rows in file order, both ports run side by side
0 0 00000000 00000000 08000020 0
0 0 00000004 00000000 00000000 0
0 0 00000080 00000000 3c1d1000 0
0 0 00000084 00000000 37bd0ffc 0
0 0 00000098 00000000 3c081000 0
0 0 0000009c 00000000 8d090000 0
0 0 000000a0 00000000 1120fffe 0
0 0 000000b0 00000000 80820000 0
0 0 000000bc 00000000 0800002f 0
0 0 00000190 00000000 00000000 0
0 0 000007fc 00000000 00000000 0
1 0 00000008 00000000 4d495053 0
1 0 0000000c 00000000 2d536f43 0
1 0 00000010 00000000 20626f6f 0
1 0 00000018 00000000 4d0d0a00 0
1 0 00000030 00000000 4152542e 0
1 0 00000050 00000000 4a756d70 0
1 0 00000064 00000000 4d656d20 0
1 0 00000078 00000000 3e200000 0
1 1 10000000 deadbeef 00000000 0
1 1 10000004 12345678 00000000 0
1 1 10000ffc a5a5a5a5 00000000 0
1 0 10000000 00000000 deadbeef 0
1 0 10000004 00000000 12345678 0
1 0 10000ffc 00000000 a5a5a5a5 0
0 0 10000000 00000000 00000000 1
0 0 00000800 00000000 00000000 1
0 0 00000802 00000000 00000000 1
0 0 20000000 00000000 00000000 1
0 1 00000000 ffffffff 00000000 1
0 0 00000000 00000000 08000020 0
1 0 10001000 00000000 00000000 1
1 0 10000002 00000000 00000000 1
1 0 30000000 00000000 00000000 1
1 1 00000010 0badf00d 00000000 1
1 1 10000006 ffffffff 00000000 1
1 1 10001000 ffffffff 00000000 1
1 0 10000000 00000000 deadbeef 0
1 0 10000004 00000000 12345678 0
1 0 00000010 00000000 20626f6f 0

// File: mem_pkg.sv
`default_nettype none

package mem_pkg;

        localparam int addr_w = 32;
        localparam int data_w = 32;

        localparam int rom_words = 512;
        localparam int rom_aw = 9;
        localparam int ram_words = 1024;
        localparam int ram_aw = 10;

        // address map, byte addresses
        localparam logic [addr_w-1:0] rom_base = 32'h0000_0000;
        localparam logic [addr_w-1:0] ram_base = 32'h1000_0000;

        // credits per direction, equal to the response queue depth
        localparam int port_credits = 2;
        localparam int q_aw = $clog2(port_credits);
        localparam int cnt_w = $clog2(port_credits + 1);
        localparam logic [q_aw-1:0] q_last = q_aw'(port_credits - 1);
        localparam logic [cnt_w-1:0] credit_max = cnt_w'(port_credits);

        typedef struct packed {
                logic we;                       // 1 = write
                logic [addr_w-1:0] addr;
                logic [data_w-1:0] wdata;
        } mem_req_t;

        typedef struct packed {
                logic [data_w-1:0] rdata;
                logic err;                      // region or alignment fault
        } mem_rsp_t;

endpackage

`default_nettype wire

// File: mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module mem_port #(
        parameter bit has_ram = 1'b0
) (
        input  logic clka,
        input  logic rst_n,
        input  logic req_valid,
        input  mem_pkg::mem_req_t req,
        output logic req_credit,
        output logic rsp_valid,
        output mem_pkg::mem_rsp_t rsp,
        input  logic rsp_credit,
        output logic rom_en,
        output logic [mem_pkg::rom_aw-1:0] rom_addr,
        input  logic [mem_pkg::data_w-1:0] rom_data,
        output logic ram_en,
        output logic ram_we,
        output logic [mem_pkg::ram_aw-1:0] ram_addr,
        output logic [mem_pkg::data_w-1:0] ram_wdata,
        input  logic [mem_pkg::data_w-1:0] ram_data
);

        logic [mem_pkg::addr_w-1:0] rom_off;
        logic [mem_pkg::addr_w-1:0] ram_off;
        logic aligned;
        logic in_rom;
        logic in_ram;
        logic hit_rom;
        logic hit_ram;

        logic s_valid;
        logic s_rom;
        logic s_ram;
        logic s_err;
        mem_pkg::mem_rsp_t s_rsp;

        mem_pkg::mem_rsp_t q_mem [mem_pkg::port_credits];
        logic [mem_pkg::q_aw-1:0] wr_ptr;
        logic [mem_pkg::q_aw-1:0] rd_ptr;
        logic [mem_pkg::cnt_w-1:0] q_cnt;
        logic [mem_pkg::cnt_w-1:0] rsp_cnt;
        logic q_empty;
        logic pop;

        function automatic logic [mem_pkg::q_aw-1:0] next_ptr(
                input logic [mem_pkg::q_aw-1:0] p
        );
                return (p == mem_pkg::q_last) ? '0 : p + 1'b1;
        endfunction

        // upper offset bits must be clear for an address to be inside a region
        assign rom_off = req.addr - mem_pkg::rom_base;
        assign ram_off = req.addr - mem_pkg::ram_base;
        assign aligned = (req.addr[1:0] == 2'b00);
        assign in_rom = (rom_off[mem_pkg::addr_w-1:mem_pkg::rom_aw+2] == '0);
        assign in_ram = has_ram && (ram_off[mem_pkg::addr_w-1:mem_pkg::ram_aw+2] == '0);

        assign hit_rom = req_valid && aligned && in_rom && !req.we;    // rom is read only
        assign hit_ram = req_valid && aligned && in_ram;

        assign rom_en = hit_rom;
        assign rom_addr = rom_off[mem_pkg::rom_aw+1:2];
        assign ram_en = hit_ram;
        assign ram_we = hit_ram && req.we;
        assign ram_addr = ram_off[mem_pkg::ram_aw+1:2];
        assign ram_wdata = req.wdata;

        // access kind lines up with the memory read latency
        always_ff @(posedge clka) begin
                if (!rst_n) begin
                        s_valid <= 1'b0;
                end else begin
                        s_valid <= req_valid;
                end
                s_rom <= hit_rom;
                s_ram <= hit_ram && !req.we;
                s_err <= !(hit_rom || hit_ram);
        end

        always_comb begin
                s_rsp.err = s_err;
                if (s_rom) begin
                        s_rsp.rdata = rom_data;
                end else if (s_ram) begin
                        s_rsp.rdata = ram_data;
                end else begin
                        s_rsp.rdata = '0;       // writes and faults
                end
        end

        // every result goes through the queue, so responses keep request order
        assign q_empty = (q_cnt == '0);
        assign rsp_valid = !q_empty && (rsp_cnt != '0);
        assign rsp = q_mem[rd_ptr];
        assign pop = rsp_valid;

        always_ff @(posedge clka) begin
                if (s_valid) begin
                        q_mem[wr_ptr] <= s_rsp;
                end
        end

        always_ff @(posedge clka) begin
                if (!rst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        q_cnt <= '0;
                        rsp_cnt <= mem_pkg::credit_max;
                        req_credit <= 1'b0;
                end else begin
                        if (s_valid) begin
                                wr_ptr <= next_ptr(wr_ptr);
                        end
                        if (pop) begin
                                rd_ptr <= next_ptr(rd_ptr);
                        end
                        case ({s_valid, pop})
                        2'b10: q_cnt <= q_cnt + 1'b1;
                        2'b01: q_cnt <= q_cnt - 1'b1;
                        default: ;
                        endcase
                        case ({rsp_credit, pop})
                        2'b10: rsp_cnt <= rsp_cnt + 1'b1;
                        2'b01: rsp_cnt <= rsp_cnt - 1'b1;
                        default: ;
                        endcase
                        req_credit <= pop;      // slot handed back to requester
                end
        end

endmodule

`default_nettype wire

// File: mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_tb;

        localparam int clk_period = 20;
        localparam int reset_cycles = 5;
        localparam int rand_seed = 7;
        localparam int max_pats = 64;           // rows per port
        localparam int cycles_per_pat = 200;

        logic clka = 1'b0;
        logic rst_n;
        logic [1:0] req_valid;                  // index 0 is port A, 1 is port B
        mem_pkg::mem_req_t [1:0] req;
        logic [1:0] req_credit;
        logic [1:0] rsp_valid;
        mem_pkg::mem_rsp_t rsp [2];
        logic [1:0] rsp_credit;

        mem_pkg::mem_req_t pat_req [2][max_pats];
        mem_pkg::mem_rsp_t pat_rsp [2][max_pats];
        int pat_cnt [2];
        int iss [2];                            // rows issued
        int rcv [2];                            // responses checked
        int credits [2];                        // request credits held
        int owed [2];                           // response credits not yet handed back
        int seed;
        int checks;
        int errors;
        logic loaded = 1'b0;

        always #(clk_period / 2) clka = ~clka;

        mem_top dut (
                .clka         (clka),
                .rst_n        (rst_n),
                .a_req_valid  (req_valid[0]),
                .a_req        (req[0]),
                .a_req_credit (req_credit[0]),
                .a_rsp_valid  (rsp_valid[0]),
                .a_rsp        (rsp[0]),
                .a_rsp_credit (rsp_credit[0]),
                .b_req_valid  (req_valid[1]),
                .b_req        (req[1]),
                .b_req_credit (req_credit[1]),
                .b_rsp_valid  (rsp_valid[1]),
                .b_rsp        (rsp[1]),
                .b_rsp_credit (rsp_credit[1])
        );

        function automatic string port_name(input int p);
                return (p == 0) ? "A" : "B";
        endfunction

        function automatic bit all_done();
                return iss[0] == pat_cnt[0] && rcv[0] == iss[0]
                        && iss[1] == pat_cnt[1] && rcv[1] == iss[1];
        endfunction

        task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("FAIL %0t: %s, got %h, expected %h", $time, what, got, exp);
                end
        endtask

        task automatic load_patterns();
                int fd;
                int n;
                int p;
                string line;
                logic [31:0] port;
                logic [31:0] we;
                logic [31:0] addr;
                logic [31:0] wdata;
                logic [31:0] rdata;
                logic [31:0] err;
                fd = $fopen("mem_patterns.txt", "r");
                if (fd == 0) begin
                        errors++;
                        $display("could not open mem_patterns.txt, no stimulus loaded");
                end else begin
                        while ($fgets(line, fd) != 0) begin
                                if (line.len() > 1 && line[0] != "#") begin  // skip column notes
                                        n = $sscanf(line, "%h %h %h %h %h %h",
                                                    port, we, addr, wdata, rdata, err);
                                        p = int'(port[0]);
                                        if (n != 6 || port > 1 || pat_cnt[p] >= max_pats) begin
                                                errors++;
                                                $display("bad pattern line: %s", line);
                                        end else begin
                                                pat_req[p][pat_cnt[p]] =
                                                        '{we: we[0], addr: addr, wdata: wdata};
                                                pat_rsp[p][pat_cnt[p]] = '{rdata: rdata, err: err[0]};
                                                pat_cnt[p]++;
                                        end
                                end
                        end
                        $fclose(fd);
                end
        endtask

        // one clock of checking responses, tracking credits and driving the next inputs
        task automatic run_cycle();
                @(posedge clka);
                for (int p = 0; p < 2; p++) begin
                        if (rsp_valid[p]) begin
                                if (rcv[p] >= iss[p]) begin
                                        errors++;
                                        $display("port %s sent a response with nothing outstanding",
                                                 port_name(p));
                                end else begin
                                        check(rsp[p].rdata, pat_rsp[p][rcv[p]].rdata,
                                              $sformatf("port %s rdata, addr %h", port_name(p),
                                                        pat_req[p][rcv[p]].addr));
                                        check(32'(rsp[p].err), 32'(pat_rsp[p][rcv[p]].err),
                                              $sformatf("port %s err, addr %h", port_name(p),
                                                        pat_req[p][rcv[p]].addr));
                                        rcv[p]++;
                                        owed[p]++;
                                end
                        end
                        if (req_credit[p]) begin
                                credits[p]++;
                                check(32'(credits[p] <= mem_pkg::port_credits), 32'd1,
                                      $sformatf("port %s credits within limit", port_name(p)));
                        end
                        // random holdback of response credits backs up the queue
                        if (owed[p] > 0 && ($random(seed) & 1) != 0) begin
                                rsp_credit[p] <= 1'b1;
                                owed[p]--;
                        end else begin
                                rsp_credit[p] <= 1'b0;
                        end
                        if (credits[p] > 0 && iss[p] < pat_cnt[p]) begin
                                req_valid[p] <= 1'b1;
                                req[p] <= pat_req[p][iss[p]];
                                credits[p]--;
                                iss[p]++;
                        end else begin
                                req_valid[p] <= 1'b0;
                        end
                end
        endtask

        initial begin
                rst_n <= 1'b0;
                req_valid <= '0;
                req[0] <= '0;
                req[1] <= '0;
                rsp_credit <= '0;
                seed = rand_seed;
                checks = 0;
                errors = 0;
                for (int p = 0; p < 2; p++) begin
                        pat_cnt[p] = 0;
                        iss[p] = 0;
                        rcv[p] = 0;
                        credits[p] = mem_pkg::port_credits;
                        owed[p] = 0;
                end
                load_patterns();
                loaded = 1'b1;
                repeat (reset_cycles) @(posedge clka);
                rst_n <= 1'b1;
                while (!all_done()) begin
                        run_cycle();
                end
                repeat (10) begin
                        run_cycle();            // late or repeated responses show up here
                end
                for (int p = 0; p < 2; p++) begin
                        check(32'(credits[p]), 32'(mem_pkg::port_credits),
                              $sformatf("port %s request credits returned", port_name(p)));
                end
                $display("%0d checks, %0d errors", checks, errors);
                if (errors == 0) begin
                        $display("No errors");
                end else begin
                        $display("Errors found");
                end
                $finish;
        end

        initial begin
                wait (loaded);
                repeat (reset_cycles + 20 + cycles_per_pat * (pat_cnt[0] + pat_cnt[1])) begin
                        @(posedge clka);
                end
                $display("timeout: port A got %0d of %0d responses, port B got %0d of %0d",
                         rcv[0], pat_cnt[0], rcv[1], pat_cnt[1]);
                $display("Errors found");
                $finish;
        end

endmodule

`default_nettype wire

// File: mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_top (
        input  logic clka,
        input  logic rst_n,
        // port A, instruction fetch
        input  logic a_req_valid,
        input  mem_pkg::mem_req_t a_req,
        output logic a_req_credit,
        output logic a_rsp_valid,
        output mem_pkg::mem_rsp_t a_rsp,
        input  logic a_rsp_credit,
        // port B, data
        input  logic b_req_valid,
        input  mem_pkg::mem_req_t b_req,
        output logic b_req_credit,
        output logic b_rsp_valid,
        output mem_pkg::mem_rsp_t b_rsp,
        input  logic b_rsp_credit
);

        logic a_rom_en;
        logic [mem_pkg::rom_aw-1:0] a_rom_addr;
        logic [mem_pkg::data_w-1:0] a_rom_data;
        logic b_rom_en;
        logic [mem_pkg::rom_aw-1:0] b_rom_addr;
        logic [mem_pkg::data_w-1:0] b_rom_data;

        logic ram_en;
        logic ram_we;
        logic [mem_pkg::ram_aw-1:0] ram_addr;
        logic [mem_pkg::data_w-1:0] ram_wdata;
        logic [mem_pkg::data_w-1:0] ram_rdata;

        boot_rom rom (
                .clka  (clka),
                .ena   (a_rom_en),
                .enb   (b_rom_en),
                .addra (a_rom_addr),
                .addrb (b_rom_addr),
                .doa   (a_rom_data),
                .dob   (b_rom_data)
        );

        data_ram ram (
                .clka  (clka),
                .en    (ram_en),
                .we    (ram_we),
                .addr  (ram_addr),
                .wdata (ram_wdata),
                .rdata (ram_rdata)
        );

        // fetch port sees the rom only
        mem_port #(.has_ram(1'b0)) port_a (
                .clka       (clka),
                .rst_n      (rst_n),
                .req_valid  (a_req_valid),
                .req        (a_req),
                .req_credit (a_req_credit),
                .rsp_valid  (a_rsp_valid),
                .rsp        (a_rsp),
                .rsp_credit (a_rsp_credit),
                .rom_en     (a_rom_en),
                .rom_addr   (a_rom_addr),
                .rom_data   (a_rom_data),
                .ram_en     (),
                .ram_we     (),
                .ram_addr   (),
                .ram_wdata  (),
                .ram_data   ('0)
        );

        mem_port #(.has_ram(1'b1)) port_b (
                .clka       (clka),
                .rst_n      (rst_n),
                .req_valid  (b_req_valid),
                .req        (b_req),
                .req_credit (b_req_credit),
                .rsp_valid  (b_rsp_valid),
                .rsp        (b_rsp),
                .rsp_credit (b_rsp_credit),
                .rom_en     (b_rom_en),
                .rom_addr   (b_rom_addr),
                .rom_data   (b_rom_data),
                .ram_en     (ram_en),
                .ram_we     (ram_we),
                .ram_addr   (ram_addr),
                .ram_wdata  (ram_wdata),
                .ram_data   (ram_rdata)
        );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and judge the run from sim.log
rm -f sim.log
verilator --binary --timing --assert -f compile.f --top-module mem_tb -o mem_sim \
        && ./obj_dir/mem_sim > sim.log 2>&1 \
        || echo "Errors found" >> sim.log
cat sim.log
! grep -q "Errors found" sim.log && echo "simulation passed" \
        || { echo "simulation failed"; exit 1; }
